// ==== build.f ====
memBusPkg.sv
coherencePkg.sv
reqArbiter.sv
snoopUnit.sv
busSequencer.sv
busCtrl.sv
busCtrl_checker.sv
busCtrlTb.sv

// ==== busCtrl.sv ====
`timescale 1ns/100ps
`default_nettype none

module busCtrl (
    input  logic                              CLK,
    input  logic                              nRST,
    // cache side
    input  logic [coherencePkg::numCores-1:0] iREN,
    input  logic [coherencePkg::numCores-1:0] dREN,
    input  logic [coherencePkg::numCores-1:0] dWEN,
    input  memBusPkg::wordT                   iaddr [coherencePkg::numCores],
    input  memBusPkg::wordT                   daddr [coherencePkg::numCores],
    input  memBusPkg::wordT                   dstore [coherencePkg::numCores],
    input  logic [coherencePkg::numCores-1:0] cctrans,
    input  logic [coherencePkg::numCores-1:0] ccwrite,
    output logic [coherencePkg::numCores-1:0] iwait,
    output logic [coherencePkg::numCores-1:0] dwait,
    output memBusPkg::wordT                   iload [coherencePkg::numCores],
    output memBusPkg::wordT                   dload [coherencePkg::numCores],
    output logic [coherencePkg::numCores-1:0] ccwait,
    output logic [coherencePkg::numCores-1:0] ccinv,
    output memBusPkg::wordT                   ccsnoopaddr [coherencePkg::numCores],
    // RAM side
    output logic                              ramREN,
    output logic                              ramWEN,
    output memBusPkg::wordT                   ramaddr,
    output memBusPkg::wordT                   ramstore,
    input  memBusPkg::wordT                   ramload,
    input  memBusPkg::ramStateT               ramstate
);
    import coherencePkg::*;

    logic   grantValid;
    busOpT  grantOp;
    coreIdT grantCore;
    logic   opDone;
    logic   snoopPhase;
    logic   invPulse;
    logic   snoopHit;
    logic   snoopDirty;

    reqArbiter uArbiter (
        .CLK        (CLK),
        .nRST       (nRST),
        .iREN       (iREN),
        .dREN       (dREN),
        .dWEN       (dWEN),
        .ccwrite    (ccwrite),
        .opDone     (opDone),
        .grantValid (grantValid),
        .grantOp    (grantOp),
        .grantCore  (grantCore)
    );

    snoopUnit uSnoop (
        .CLK         (CLK),
        .nRST        (nRST),
        .grantCore   (grantCore),
        .daddr       (daddr),
        .cctrans     (cctrans),
        .ccwrite     (ccwrite),
        .snoopPhase  (snoopPhase),
        .invPulse    (invPulse),
        .ccwait      (ccwait),
        .ccinv       (ccinv),
        .ccsnoopaddr (ccsnoopaddr),
        .snoopHit    (snoopHit),
        .snoopDirty  (snoopDirty)
    );

    busSequencer uSequencer (
        .CLK        (CLK),
        .nRST       (nRST),
        .grantValid (grantValid),
        .grantOp    (grantOp),
        .grantCore  (grantCore),
        .iREN       (iREN),
        .dREN       (dREN),
        .dWEN       (dWEN),
        .iaddr      (iaddr),
        .daddr      (daddr),
        .dstore     (dstore),
        .ramload    (ramload),
        .ramstate   (ramstate),
        .snoopHit   (snoopHit),
        .snoopDirty (snoopDirty),
        .ramREN     (ramREN),
        .ramWEN     (ramWEN),
        .ramaddr    (ramaddr),
        .ramstore   (ramstore),
        .iwait      (iwait),
        .dwait      (dwait),
        .iload      (iload),
        .dload      (dload),
        .snoopPhase (snoopPhase),
        .invPulse   (invPulse),
        .opDone     (opDone)
    );

endmodule

`default_nettype wire

// ==== busCtrlTb.sv ====
`timescale 1ns/100ps
`default_nettype none

module busCtrlTb;
    import memBusPkg::*;

    localparam int period = 100;
    localparam int timeoutCycles = 200;

    logic       CLK;
    logic       nRST;
    logic [1:0] iREN;
    logic [1:0] dREN;
    logic [1:0] dWEN;
    logic [1:0] cctrans;
    logic [1:0] ccwrite;
    logic [1:0] iwait;
    logic [1:0] dwait;
    logic [1:0] ccwait;
    logic [1:0] ccinv;
    wordT       iaddr [2];
    wordT       daddr [2];
    wordT       dstore [2];
    wordT       iload [2];
    wordT       dload [2];
    wordT       ccsnoopaddr [2];
    logic       ramREN;
    logic       ramWEN;
    wordT       ramaddr;
    wordT       ramstore;
    wordT       ramload;
    ramStateT   ramstate;

    wordT ramMem [1024];
    wordT stimMem [256];
    int   seed = 47707;

    busCtrl u_dut (.*);

    bind busCtrl busCtrl_checker uChecker (
        .CLK    (CLK),
        .nRST   (nRST),
        .ramREN (ramREN),
        .ramWEN (ramWEN),
        .dREN   (dREN),
        .dWEN   (dWEN),
        .dwait  (dwait),
        .ccwait (ccwait),
        .ccinv  (ccinv)
    );

    // RAM preset tags every word with its own byte address
    function automatic wordT fillWord(input wordT addr);
        return 32'hC0DE0000 + {addr[31:2], 2'b00};
    endfunction

    initial begin
        CLK = 1'b0;
        forever #(period / 2) CLK = ~CLK;
    end

    // RAM model decided at the falling edge with 1 to 3 busy cycles per word
    initial begin
        int   busyLeft;
        logic busyArmed;
        busyLeft = 0;
        busyArmed = 1'b0;
        ramstate <= ramFree;
        ramload <= '0;
        for (int i = 0; i < 1024; i++) begin
            ramMem[i[9:0]] = fillWord(i * 4);
        end
        forever begin
            @(negedge CLK);
            if (!(ramREN || ramWEN)) begin
                busyArmed = 1'b0;
                ramstate <= ramFree;
            end else begin
                if (!busyArmed) begin
                    busyArmed = 1'b1;
                    busyLeft = 1 + ($unsigned($random(seed)) % 3);
                end
                if (busyLeft > 0) begin
                    busyLeft--;
                    ramstate <= ramBusy;
                end else begin
                    busyArmed = 1'b0;
                    ramstate <= ramAccess;
                    if (ramWEN) begin
                        ramMem[ramaddr[11:2]] = ramstore;
                    end else begin
                        ramload <= ramMem[ramaddr[11:2]];
                    end
                end
            end
        end
    end

    task automatic failRun(input string why);
        $display("%s", why);
        $display("Result: FAILED");
        $fatal(1, "simulation stopped");
    endtask

    task automatic checkValue(input string testName, input wordT expected, input wordT actual);
        if (expected !== actual) begin
            failRun($sformatf("ERROR %s: expected %h, actual %h", testName, expected, actual));
        end
    endtask

    // sample point in the low half of the clock
    task automatic sampleCycle();
        @(negedge CLK);
        #5;
    endtask

    task automatic fetchOneWord(input string name, input logic core, input wordT addr,
                                input wordT expected);
        int cycles;
        cycles = 0;
        iREN[core] = 1'b1;
        iaddr[core] = addr;
        do begin
            sampleCycle();
            cycles++;
            if (cycles > timeoutCycles) begin
                failRun($sformatf("%s: timed out waiting for iwait to drop", name));
            end
        end while (iwait[core]);
        checkValue(name, expected, iload[core]);
        @(posedge CLK);
        #10;
        iREN[core] = 1'b0;
    endtask

    // snooped cache side of one cycle with the snoop checks
    task automatic watchCycle(input string name, input wordT op, input logic core,
                              input wordT addr, inout int invCount,
                              output logic flushTaken);
        logic other;
        other = ~core;
        checkValue({name, " requester invalidate"}, '0, 32'(ccinv[core]));
        if (ccinv[other]) begin
            invCount++;
        end
        if (op == 3) begin
            checkValue({name, " ccwait"}, '0, 32'(ccwait));
        end else if (ccwait[other]) begin
            checkValue({name, " snoop address"}, addr, ccsnoopaddr[other]);
        end
        // a dirty word is written while its owner is stalled
        flushTaken = ramWEN && ramstate == ramAccess && ccwait[other];
    endtask

    task automatic blockTransfer(input string name, input wordT op, input logic core,
                                 input wordT addr, input wordT d0, input wordT d1,
                                 input wordT snoop, input wordT e0, input wordT e1);
        logic other;
        logic waiting;
        logic flushTaken;
        int   cycles;
        int   invCount;
        other = ~core;
        invCount = 0;
        cctrans[other] = snoop[0];
        ccwrite[other] = snoop[1];
        dstore[other] = d0;
        daddr[core] = addr;
        dstore[core] = d0;
        if (op == 3) begin
            dWEN[core] = 1'b1;
        end else begin
            dREN[core] = 1'b1;
            ccwrite[core] = (op == 2);
        end
        for (int w = 0; w < 2; w++) begin
            cycles = 0;
            do begin
                sampleCycle();
                cycles++;
                if (cycles > timeoutCycles) begin
                    failRun($sformatf("%s: timed out waiting for dwait, word %0d", name, w));
                end
                watchCycle(name, op, core, addr, invCount, flushTaken);
                waiting = dwait[core];
                if (flushTaken) begin
                    // first dirty word taken, the snooped cache puts up the second
                    @(posedge CLK);
                    #10;
                    dstore[other] = d1;
                end
            end while (waiting);
            if (op == 3) begin
                if (w == 0) begin
                    @(posedge CLK);
                    #10;
                    dstore[core] = d1;
                end
            end else begin
                checkValue($sformatf("%s word %0d", name, w), (w == 0) ? e0 : e1, dload[core]);
            end
        end
        @(posedge CLK);
        #10;
        dREN[core] = 1'b0;
        dWEN[core] = 1'b0;
        ccwrite[core] = 1'b0;
        // invalidate shows up just after the last fill word
        repeat (3) begin
            sampleCycle();
            watchCycle(name, op, core, addr, invCount, flushTaken);
        end
        checkValue({name, " invalidate count"}, (op == 2 && snoop[0]) ? 1 : 0, invCount);
        @(posedge CLK);
        #10;
        cctrans[other] = 1'b0;
        ccwrite[other] = 1'b0;
    endtask

    // core 1 fetch, core 1 read and core 0 read all raised together
    task automatic priorityRace(input string name, input wordT addr);
        int cycles;
        int cnt0;
        int cnt1;
        int cntF;
        int order [$];
        cycles = 0;
        cnt0 = 0;
        cnt1 = 0;
        cntF = 0;
        daddr[0] = addr;
        daddr[1] = addr + 32'h40;
        iaddr[1] = addr + 32'h80;
        dREN[0] = 1'b1;
        dREN[1] = 1'b1;
        iREN[1] = 1'b1;
        while (dREN[0] || dREN[1] || iREN[1]) begin
            sampleCycle();
            cycles++;
            if (cycles > timeoutCycles) begin
                failRun($sformatf("%s: timed out waiting for the competing requests", name));
            end
            if (!dwait[0]) begin
                if (cnt0 == 0) begin
                    order.push_back(0);
                end
                checkValue({name, " core 0 read"}, fillWord(addr + 32'(4 * cnt0)), dload[0]);
                cnt0++;
            end
            if (!dwait[1]) begin
                if (cnt1 == 0) begin
                    order.push_back(1);
                end
                checkValue({name, " core 1 read"}, fillWord(addr + 32'h40 + 32'(4 * cnt1)),
                           dload[1]);
                cnt1++;
            end
            if (!iwait[1]) begin
                order.push_back(2);
                checkValue({name, " core 1 fetch"}, fillWord(addr + 32'h80), iload[1]);
                cntF++;
            end
            if (cnt0 == 2 || cnt1 == 2 || cntF == 1) begin
                @(posedge CLK);
                #10;
                if (cnt0 == 2) begin
                    dREN[0] = 1'b0;
                end
                if (cnt1 == 2) begin
                    dREN[1] = 1'b0;
                end
                if (cntF == 1) begin
                    iREN[1] = 1'b0;
                end
            end
        end
        checkValue({name, " completions"}, 3, 32'(order.size()));
        checkValue({name, " first"}, 0, 32'(order[0]));
        checkValue({name, " second"}, 1, 32'(order[1]));
        checkValue({name, " third"}, 2, 32'(order[2]));
    endtask

    initial begin
        logic [7:0] base;
        wordT       op;
        string      name;
        nRST = 1'b0;
        iREN = '0;
        dREN = '0;
        dWEN = '0;
        cctrans = '0;
        ccwrite = '0;
        for (int c = 0; c < 2; c++) begin
            iaddr[c[0]] = '0;
            daddr[c[0]] = '0;
            dstore[c[0]] = '0;
        end
        for (int i = 0; i < 256; i++) begin
            stimMem[i[7:0]] = '1;
        end
        $readmemh("bus_stim.txt", stimMem);
        repeat (3) @(posedge CLK);
        #10;
        nRST = 1'b1;
        @(posedge CLK);
        #10;
        checkValue("reset outputs", '0, 32'({ramREN, ramWEN, ccwait, ccinv}));
        base = 8'd0;
        while (stimMem[base] != '1) begin
            op = stimMem[base];
            name = $sformatf("test %0d op %0d", base / 8, op);
            case (op)
                0: fetchOneWord(name, stimMem[base + 8'd1][0], stimMem[base + 8'd2],
                                stimMem[base + 8'd6]);
                4: priorityRace(name, stimMem[base + 8'd2]);
                default: blockTransfer(name, op, stimMem[base + 8'd1][0], stimMem[base + 8'd2],
                                       stimMem[base + 8'd3], stimMem[base + 8'd4],
                                       stimMem[base + 8'd5], stimMem[base + 8'd6],
                                       stimMem[base + 8'd7]);
            endcase
            base = base + 8'd8;
        end
        $display("Result: PASSED");
        $finish;
    end

endmodule

`default_nettype wire

// ==== busCtrl_checker.sv ====
`timescale 1ns/100ps
`default_nettype none

module busCtrl_checker (
    input logic                              CLK,
    input logic                              nRST,
    input logic                              ramREN,
    input logic                              ramWEN,
    input logic [coherencePkg::numCores-1:0] dREN,
    input logic [coherencePkg::numCores-1:0] dWEN,
    input logic [coherencePkg::numCores-1:0] dwait,
    input logic [coherencePkg::numCores-1:0] ccwait,
    input logic [coherencePkg::numCores-1:0] ccinv
);
    import coherencePkg::*;

    // RAM takes one command at a time
    assert property (@(posedge CLK) disable iff (!nRST) !(ramREN && ramWEN))
        else $error("ramREN and ramWEN high in the same cycle");

    // only one cache is ever stalled by a snoop
    assert property (@(posedge CLK) disable iff (!nRST) $onehot0(ccwait))
        else $error("ccwait high to both cores");

    for (genvar c = 0; c < numCores; c++) begin : perCore
        assert property (@(posedge CLK) disable iff (!nRST) !dwait[c] |-> (dREN[c] || dWEN[c]))
            else $error("dwait low without a data request on core %0d", c);

        // invalidate never lasts two cycles
        assert property (@(posedge CLK) disable iff (!nRST) ccinv[c] |=> !ccinv[c])
            else $error("ccinv longer than one cycle on core %0d", c);
    end

endmodule

`default_nettype wire

// ==== busSequencer.sv ====
`timescale 1ns/100ps
`default_nettype none

module busSequencer (
    input  logic                              CLK,
    input  logic                              nRST,
    input  logic                              grantValid,
    input  coherencePkg::busOpT               grantOp,
    input  coherencePkg::coreIdT              grantCore,
    input  logic [coherencePkg::numCores-1:0] iREN,
    input  logic [coherencePkg::numCores-1:0] dREN,
    input  logic [coherencePkg::numCores-1:0] dWEN,
    input  memBusPkg::wordT                   iaddr [coherencePkg::numCores],
    input  memBusPkg::wordT                   daddr [coherencePkg::numCores],
    input  memBusPkg::wordT                   dstore [coherencePkg::numCores],
    input  memBusPkg::wordT                   ramload,
    input  memBusPkg::ramStateT               ramstate,
    input  logic                              snoopHit,
    input  logic                              snoopDirty,
    output logic                              ramREN,
    output logic                              ramWEN,
    output memBusPkg::wordT                   ramaddr,
    output memBusPkg::wordT                   ramstore,
    output logic [coherencePkg::numCores-1:0] iwait,
    output logic [coherencePkg::numCores-1:0] dwait,
    output memBusPkg::wordT                   iload [coherencePkg::numCores],
    output memBusPkg::wordT                   dload [coherencePkg::numCores],
    output logic                              snoopPhase,
    output logic                              invPulse,
    output logic                              opDone
);
    import memBusPkg::*;
    import coherencePkg::*;

    seqStateT state;
    seqStateT nextState;
    coreIdT   otherCore;
    busAddrU  reqAddr;
    wordT     word0Addr;
    wordT     word1Addr;
    logic     ramReady;
    logic     iAck;
    logic     dAck;

    assign otherCore = ~grantCore;
    assign ramReady = (ramstate == ramAccess);

    // both block words come from the block field, whatever word was asked for
    assign reqAddr = daddr[grantCore];
    assign word0Addr = {reqAddr.fields.block, 1'b0, {offsetBits{1'b0}}};
    assign word1Addr = {reqAddr.fields.block, 1'b1, {offsetBits{1'b0}}};

    // a word only moves on when the RAM reports access,
    // otherwise the command is repeated as is
    always_comb begin
        nextState = state;
        ramREN = 1'b0;
        ramWEN = 1'b0;
        ramaddr = word0Addr;
        ramstore = dstore[grantCore];
        iAck = 1'b0;
        dAck = 1'b0;
        opDone = 1'b0;

        case (state)
            sIdle: begin
                if (grantValid) begin
                    case (grantOp)
                        opFetch:  nextState = sFetch;
                        opEvict:  nextState = sEvict0;
                        default:  nextState = sSnoop;
                    endcase
                end
            end
            sSnoop: begin
                nextState = snoopDirty ? sFlush0 : sFill0;
            end
            sFlush0: begin
                // dirty copy comes off the snooped core's store bus
                ramWEN = 1'b1;
                ramstore = dstore[otherCore];
                if (ramReady) begin
                    nextState = sFlush1;
                end
            end
            sFlush1: begin
                ramWEN = 1'b1;
                ramaddr = word1Addr;
                ramstore = dstore[otherCore];
                if (ramReady) begin
                    nextState = sFill0;
                end
            end
            sFill0: begin
                ramREN = 1'b1;
                dAck = ramReady;
                if (ramReady) begin
                    nextState = sFill1;
                end
            end
            sFill1: begin
                ramREN = 1'b1;
                ramaddr = word1Addr;
                dAck = ramReady;
                opDone = ramReady;
                if (ramReady) begin
                    nextState = sIdle;
                end
            end
            sFetch: begin
                ramREN = 1'b1;
                ramaddr = iaddr[grantCore];
                iAck = ramReady;
                opDone = ramReady;
                if (ramReady) begin
                    nextState = sIdle;
                end
            end
            sEvict0: begin
                ramWEN = 1'b1;
                dAck = ramReady;
                if (ramReady) begin
                    nextState = sEvict1;
                end
            end
            sEvict1: begin
                ramWEN = 1'b1;
                ramaddr = word1Addr;
                dAck = ramReady;
                opDone = ramReady;
                if (ramReady) begin
                    nextState = sIdle;
                end
            end
            default: nextState = sIdle;
        endcase
    end

    // waits drop only for the granted port with its request still up
    always_comb begin
        for (int c = 0; c < numCores; c++) begin
            iwait[c] = !(iAck && iREN[c] && (grantCore == coreIdT'(c)));
            dwait[c] = !(dAck && (dREN[c] || dWEN[c]) && (grantCore == coreIdT'(c)));
            iload[c] = (grantCore == coreIdT'(c)) ? ramload : '0;
            dload[c] = (grantCore == coreIdT'(c)) ? ramload : '0;
        end
    end

    // whole snooped transaction, snoop through the last fill word
    assign snoopPhase = state inside {sSnoop, sFlush0, sFlush1, sFill0, sFill1};

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            state <= sIdle;
            invPulse <= 1'b0;
        end else begin
            state <= nextState;
            // invalidate lands the cycle after the last fill word
            invPulse <= (state == sFill1) && ramReady && (grantOp == opReadExcl) && snoopHit;
        end
    end

endmodule

`default_nettype wire

// ==== bus_stim.txt ====
// op: 0 fetch, 1 read shared, 2 read exclusive, 3 evict, 4 priority race
// op core addr data0 data1 snoop(bit0 hit, bit1 dirty) expect0 expect1
0 0 00000040 00000000 00000000 0 C0DE0040 00000000
0 1 00000084 00000000 00000000 0 C0DE0084 00000000
1 0 00000104 00000000 00000000 0 C0DE0100 C0DE0104
1 1 00000200 00000000 00000000 1 C0DE0200 C0DE0204
1 0 00000308 11112222 33334444 3 11112222 33334444
0 1 00000308 00000000 00000000 0 11112222 00000000
0 1 0000030C 00000000 00000000 0 33334444 00000000
2 1 00000400 00000000 00000000 1 C0DE0400 C0DE0404
2 0 0000050C AAAA0001 AAAA0002 3 AAAA0001 AAAA0002
0 1 00000508 00000000 00000000 0 AAAA0001 00000000
3 0 00000600 DEAD0001 DEAD0002 0 00000000 00000000
0 1 00000600 00000000 00000000 0 DEAD0001 00000000
0 0 00000604 00000000 00000000 0 DEAD0002 00000000
3 1 00000704 BEEF0003 BEEF0004 0 00000000 00000000
0 0 00000700 00000000 00000000 0 BEEF0003 00000000
0 1 00000704 00000000 00000000 0 BEEF0004 00000000
4 0 00000800 00000000 00000000 0 00000000 00000000

// ==== coherencePkg.sv ====
`default_nettype none

package coherencePkg;

    // two cores, each with one instruction port and one data port
    localparam int numCores = 2;

    typedef logic [$clog2(numCores)-1:0] coreIdT;

    // operation held by the arbiter for the sequencer
    typedef enum logic [1:0] {
        opFetch,
        opReadShared,
        opReadExcl,
        opEvict
    } busOpT;

    // sequencer states
    // flush writes the snooped core's dirty block before a fill
    typedef enum logic [3:0] {
        sIdle,
        sSnoop,
        sFlush0,
        sFlush1,
        sFill0,
        sFill1,
        sFetch,
        sEvict0,
        sEvict1
    } seqStateT;

endpackage

`default_nettype wire

// ==== memBusPkg.sv ====
`default_nettype none

package memBusPkg;

    // one bus word, byte addressed
    localparam int wordBits = 32;

    // byte offset inside a word, then one bit to pick the word of a block
    localparam int offsetBits = 2;
    localparam int blockBits = wordBits - offsetBits - 1;

    typedef logic [wordBits-1:0] wordT;

    // status reported by the RAM for the command it is given
    typedef enum logic [1:0] {
        ramFree,
        ramBusy,
        ramAccess,
        ramError
    } ramStateT;

    // byte address seen two ways
    // raw word for snoop compare, fields for building block word addresses
    typedef union packed {
        wordT raw;
        struct packed {
            logic [blockBits-1:0]  block;
            logic                  wordSel;
            logic [offsetBits-1:0] byteOff;
        } fields;
    } busAddrU;

endpackage

`default_nettype wire

// ==== reqArbiter.sv ====
`timescale 1ns/100ps
`default_nettype none

module reqArbiter (
    input  logic                              CLK,
    input  logic                              nRST,
    input  logic [coherencePkg::numCores-1:0] iREN,
    input  logic [coherencePkg::numCores-1:0] dREN,
    input  logic [coherencePkg::numCores-1:0] dWEN,
    input  logic [coherencePkg::numCores-1:0] ccwrite,
    input  logic                              opDone,
    output logic                              grantValid,
    output coherencePkg::busOpT               grantOp,
    output coherencePkg::coreIdT              grantCore
);
    import coherencePkg::*;

    logic   pickValid;
    busOpT  pickOp;
    coreIdT pickCore;

    // later assignments win, so walk from lowest rank to highest
    always_comb begin
        pickValid = 1'b0;
        pickOp = opFetch;
        pickCore = '0;

        // fetches rank below every data request
        for (int c = numCores - 1; c >= 0; c--) begin
            if (iREN[c]) begin
                pickValid = 1'b1;
                pickOp = opFetch;
                pickCore = coreIdT'(c);
            end
        end

        // data ports, core 0 first, write before read
        for (int c = numCores - 1; c >= 0; c--) begin
            if (dWEN[c] || dREN[c]) begin
                pickValid = 1'b1;
                pickCore = coreIdT'(c);
                if (dWEN[c]) begin
                    pickOp = opEvict;
                end else if (ccwrite[c]) begin
                    // read for ownership
                    pickOp = opReadExcl;
                end else begin
                    pickOp = opReadShared;
                end
            end
        end
    end

    // a new grant only loads while nothing is granted
    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            grantValid <= 1'b0;
            grantOp <= opFetch;
            grantCore <= '0;
        end else if (!grantValid) begin
            if (pickValid) begin
                grantValid <= 1'b1;
                grantOp <= pickOp;
                grantCore <= pickCore;
            end
        end else if (opDone) begin
            // op and core stay put until the next grant
            grantValid <= 1'b0;
        end
    end

endmodule

`default_nettype wire

// ==== run.sh ====
#!/bin/sh
# compile and run the bus controller testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f build.f --top-module busCtrlTb -o busCtrlSim
if [ $? -ne 0 ]; then
    echo "compile failed"
    exit 1
fi

output=$(./obj_dir/busCtrlSim)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if echo "$output" | grep -q "^Result: PASSED$"; then
    exit 0
fi
exit 1

// ==== snoopUnit.sv ====
`timescale 1ns/100ps
`default_nettype none

module snoopUnit (
    input  logic                              CLK,
    input  logic                              nRST,
    input  coherencePkg::coreIdT              grantCore,
    input  memBusPkg::wordT                   daddr [coherencePkg::numCores],
    input  logic [coherencePkg::numCores-1:0] cctrans,
    input  logic [coherencePkg::numCores-1:0] ccwrite,
    input  logic                              snoopPhase,
    input  logic                              invPulse,
    output logic [coherencePkg::numCores-1:0] ccwait,
    output logic [coherencePkg::numCores-1:0] ccinv,
    output memBusPkg::wordT                   ccsnoopaddr [coherencePkg::numCores],
    output logic                              snoopHit,
    output logic                              snoopDirty
);
    import memBusPkg::*;
    import coherencePkg::*;

    coreIdT  target;
    busAddrU reqAddr;
    logic    phaseQ;
    logic    firstCycle;
    logic    liveHit;
    logic    liveDirty;
    logic    hitQ;
    logic    dirtyQ;

    // with two cores the snooped cache is simply the other one
    assign target = ~grantCore;
    assign reqAddr = daddr[grantCore];

    assign firstCycle = snoopPhase && !phaseQ;
    assign liveHit = cctrans[target];
    assign liveDirty = cctrans[target] && ccwrite[target];

    always_comb begin
        for (int c = 0; c < numCores; c++) begin
            // snooped cache stays stalled through the invalidate cycle too
            ccwait[c] = (snoopPhase || invPulse) && (target == coreIdT'(c));
            ccinv[c] = invPulse && (target == coreIdT'(c));
            ccsnoopaddr[c] = (target == coreIdT'(c)) ? reqAddr.raw : '0;
        end
    end

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            phaseQ <= 1'b0;
            hitQ <= 1'b0;
            dirtyQ <= 1'b0;
        end else begin
            phaseQ <= snoopPhase;
            if (firstCycle) begin
                hitQ <= liveHit;
                dirtyQ <= liveDirty;
            end
        end
    end

    // live reply during the snoop cycle so the sequencer can branch on it,
    // the held copy for the rest of the transaction
    assign snoopHit = firstCycle ? liveHit : hitQ;
    assign snoopDirty = firstCycle ? liveDirty : dirtyQ;

endmodule

`default_nettype wire
